/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module uartPeriphTb -f sim.f \
    --Mdir obj_dir -o uartPeriphSim
./obj_dir/uartPeriphSim | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* sim.f */
+incdir+verilog
verilog/uartBusPkg.sv
verilog/uartLinePkg.sv
verilog/uartRegFile.sv
verilog/byteFifo.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/uartPeriph.sv
sim/uartPeriphTb.sv

/* sim/uartPeriphTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module uartPeriphTb;

    localparam int CLK_PERIOD = 100;

    logic                       clk;
    logic                       rst;
    logic                       slaveSel;
    logic [`UART_ADDR_BITS-1:0] regAddr;
    logic [3:0]                 byteEn;
    logic                       readStb;
    logic                       writeStb;
    logic [31:0]                writeData;
    logic [31:0]                readData;
    logic                       uartTx;
    wire                        uartRx;

    integer      seed;
    int          errorCount;
    int          checkCount;
    logic        monitorOn;
    logic [15:0] modelDiv;
    logic [7:0]  txExpQ[$];
    logic [7:0]  rxExpQ[$];

    // Serial loopback
    assign uartRx = uartTx;

    uartPeriph dut0 (
        .i_Clk       (clk),
        .i_rst       (rst),
        .i_SlaveSel  (slaveSel),
        .i_RegAddr   (regAddr),
        .i_ByteEn    (byteEn),
        .i_Read      (readStb),
        .i_Write     (writeStb),
        .i_WriteData (writeData),
        .i_UartRx    (uartRx),
        .o_ReadData  (readData),
        .o_UartTx    (uartTx)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] expectStatus(input logic [15:0] div, input int txQueued,
                                                 input logic txBusy, input int rxQueued);
        logic [31:0] word;
        word = '0;
        word[busPkg::DIV_MSB:0] = div;
        word[busPkg::STAT_TX_IDLE] = (txQueued == 0) && !txBusy;
        word[busPkg::STAT_RX_AVAIL] = (rxQueued != 0);
        word[busPkg::STAT_TX_FULL] = (txQueued >= `UART_FIFO_DEPTH);
        return word;
    endfunction

    // Index 0 is the start bit, data goes out LSB first
    function automatic logic [9:0] expectFrame(input logic [7:0] data);
        return {1'b1, data, 1'b0};
    endfunction

    task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkLine(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Timed out waiting for %s at %0t ns", reason, $time);
        $display("Checks: %0d, errors: %0d, timeouts: 1", checkCount, errorCount);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic busWrite(input busPkg::regAddr_t addr, input logic [3:0] be,
                            input logic [31:0] data);
        @(posedge clk);
        #1;
        slaveSel  = 1'b1;
        writeStb  = 1'b1;
        regAddr   = addr;
        byteEn    = be;
        writeData = data;
        @(posedge clk);
        #1;
        slaveSel  = 1'b0;
        writeStb  = 1'b0;
        byteEn    = 4'b0000;
        writeData = '0;
    endtask

    // Read data is registered, so it is stable just after the edge
    task automatic busRead(input busPkg::regAddr_t addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        slaveSel = 1'b1;
        readStb  = 1'b1;
        regAddr  = addr;
        @(posedge clk);
        #1;
        slaveSel = 1'b0;
        readStb  = 1'b0;
        data     = readData;
    endtask

    task automatic writeDivisor(input logic [3:0] be, input logic [31:0] data);
        logic [31:0] rd;
        busWrite(busPkg::REG_CTRL, be, data);
        if (be[0]) begin
            modelDiv[7:0] = data[7:0];
        end
        if (be[1]) begin
            modelDiv[15:8] = data[15:8];
        end
        busRead(busPkg::REG_CTRL, rd);
        checkWord(rd, expectStatus(modelDiv, 0, 1'b0, 0), "divisor readback");
    endtask

    task automatic sendByte(input logic [7:0] data);
        txExpQ.push_back(data);
        rxExpQ.push_back(data);
        busWrite(busPkg::REG_DATA, 4'b0001, {24'hA5A5A5, data});
    endtask

    task automatic matchReceived(input logic [31:0] rd);
        logic [7:0] expByte;
        if (rxExpQ.size() == 0) begin
            errorCount++;
            $display("Receive FIFO returned a byte that was never sent, at %0t ns", $time);
        end else begin
            expByte = rxExpQ.pop_front();
            checkWord(rd, {24'b0, expByte}, "received byte");
        end
    endtask

    task automatic receiveByte();
        logic [31:0] rd;
        int          polls;
        int          limit;
        polls = 0;
        limit = 20 * int'(modelDiv) + 50;
        rd = '0;
        while (!rd[busPkg::STAT_RX_AVAIL] && polls < limit) begin
            busRead(busPkg::REG_CTRL, rd);
            polls++;
        end
        if (!rd[busPkg::STAT_RX_AVAIL]) begin
            abortRun("a received byte");
        end
        busRead(busPkg::REG_DATA, rd);
        matchReceived(rd);
    endtask

    task automatic waitTxDrained();
        int cycles;
        int limit;
        cycles = 0;
        limit = (txExpQ.size() + 1) * 12 * int'(modelDiv) + 50;
        while (txExpQ.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (txExpQ.size() != 0) begin
            abortRun("the expected frames on o_UartTx");
        end
    endtask

    // Receive side is read while the transmitter works through its queue
    task automatic drainUntilIdle();
        logic [31:0] st;
        logic [31:0] rd;
        int          polls;
        int          limit;
        polls = 0;
        limit = 200 * int'(modelDiv);
        st = '0;
        while (!st[busPkg::STAT_TX_IDLE] && polls < limit) begin
            busRead(busPkg::REG_CTRL, st);
            if (st[busPkg::STAT_RX_AVAIL]) begin
                busRead(busPkg::REG_DATA, rd);
                matchReceived(rd);
            end
            polls++;
        end
        if (!st[busPkg::STAT_TX_IDLE]) begin
            abortRun("TX_IDLE after the full FIFO burst");
        end
        while (rxExpQ.size() != 0) begin
            receiveByte();
        end
    endtask

    // First, middle and last clock of one bit period
    task automatic sampleBit(input int bitNum, output logic level);
        logic firstLevel;
        firstLevel = uartTx;
        repeat (modelDiv / 2) @(negedge clk);
        level = uartTx;
        repeat (modelDiv - 16'd1 - modelDiv / 2) @(negedge clk);
        checkLine(firstLevel, level, $sformatf("frame bit %0d at bit start", bitNum));
        checkLine(uartTx, level, $sformatf("frame bit %0d at bit end", bitNum));
    endtask

    initial begin : lineMonitor
        logic [9:0] levels;
        logic [9:0] expLevels;
        logic       lvl;
        int         idleCycles;
        idleCycles = 0;
        forever begin
            @(negedge clk);
            if (!monitorOn) begin
                idleCycles = 0;
            end else if (uartTx === 1'b0) begin
                idleCycles = 0;
                for (int b = 0; b < 10; b++) begin
                    sampleBit(b, lvl);
                    levels[b] = lvl;
                    if (b < 9) begin
                        @(negedge clk);
                    end
                end
                if (txExpQ.size() == 0) begin
                    errorCount++;
                    $display("Unexpected frame on o_UartTx ending at %0t ns", $time);
                end else begin
                    expLevels = expectFrame(txExpQ[0]);
                    for (int b = 0; b < 10; b++) begin
                        checkLine(levels[b], expLevels[b], $sformatf("frame bit %0d", b));
                    end
                    checkByte(levels[8:1], txExpQ[0], "serial frame data");
                    void'(txExpQ.pop_front());
                end
            end else if (txExpQ.size() != 0) begin
                idleCycles++;
                if (idleCycles > 12 * int'(modelDiv) + 20) begin
                    abortRun("a start bit on o_UartTx");
                end
            end
        end
    end

    initial begin : mainTest
        logic [31:0] rd;
        logic [7:0]  data;
        int          burst;
        seed       = 32'h4c8b;
        errorCount = 0;
        checkCount = 0;
        monitorOn  = 1'b0;
        modelDiv   = 16'(`UART_RESET_CLKS_PER_BIT);
        rst        = 1'b1;
        slaveSel   = 1'b0;
        regAddr    = busPkg::REG_CTRL;
        byteEn     = 4'b0000;
        readStb    = 1'b0;
        writeStb   = 1'b0;
        writeData  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst       = 1'b0;
        monitorOn = 1'b1;

        checkLine(uartTx, 1'b1, "serial line after reset");
        busRead(busPkg::REG_CTRL, rd);
        checkWord(rd, expectStatus(modelDiv, 0, 1'b0, 0), "status after reset");

        // Divisor bytes, upper byte enables have no effect
        writeDivisor(4'b0001, 32'hFFFF_FF0C);
        writeDivisor(4'b0010, 32'h5A5A_12A5);
        writeDivisor(4'b1100, 32'h0000_0000);
        writeDivisor(4'b0011, 32'h7777_000A);

        // Single frame, then a data write without byte 0 that pushes nothing
        sendByte(8'hC5);
        waitTxDrained();
        receiveByte();
        busWrite(busPkg::REG_DATA, 4'b1110, 32'h1234_5678);

        burst = 1 + ($random(seed) & 15);
        for (int i = 0; i < burst; i++) begin
            sendByte(8'($random(seed)));
        end
        for (int i = 0; i < burst; i++) begin
            receiveByte();
        end
        waitTxDrained();
        busRead(busPkg::REG_DATA, rd);
        checkWord(rd, 32'h0, "data read with empty receive FIFO");

        // Overrun the transmit FIFO, one byte sits in the transmitter
        writeDivisor(4'b0011, 32'h0000_0030);
        for (int i = 0; i < 20; i++) begin
            data = 8'($random(seed));
            if (i <= `UART_FIFO_DEPTH) begin
                txExpQ.push_back(data);
                rxExpQ.push_back(data);
            end
            busWrite(busPkg::REG_DATA, 4'b0001, {24'h0, data});
        end
        busRead(busPkg::REG_CTRL, rd);
        checkWord(rd, expectStatus(modelDiv, `UART_FIFO_DEPTH, 1'b1, 0), "status with full FIFO");
        drainUntilIdle();
        waitTxDrained();
        busRead(busPkg::REG_CTRL, rd);
        checkWord(rd, expectStatus(modelDiv, 0, 1'b0, 0), "status after burst");
        busRead(busPkg::REG_DATA, rd);
        checkWord(rd, 32'h0, "data read after burst");

        $display("Checks: %0d, errors: %0d, timeouts: 0", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/byteFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module byteFifo #(
    parameter int DEPTH_BITS = 4
) (
    input  wire logic       i_Clk,
    input  wire logic       i_rst,
    input  wire logic       i_WrEn,
    input  wire logic [7:0] i_WrData,
    input  wire logic       i_RdEn,
    output logic      [7:0] o_RdData,
    output logic            o_Full,
    output logic            o_Empty
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    logic [7:0]            mem [DEPTH];
    logic [DEPTH_BITS-1:0] wrPtr;
    logic [DEPTH_BITS-1:0] rdPtr;
    logic [DEPTH_BITS:0]   count;
    logic                  doWrite;
    logic                  doRead;

    assign o_Full   = (count == (DEPTH_BITS+1)'(DEPTH));
    assign o_Empty  = (count == '0);
    assign doWrite  = i_WrEn && !o_Full;
    assign doRead   = i_RdEn && !o_Empty;
    assign o_RdData = mem[rdPtr];

    always_ff @(posedge i_Clk) begin
        if (doWrite) begin
            mem[wrPtr] <= i_WrData;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge i_Clk) disable iff (i_rst)
        (count <= (DEPTH_BITS+1)'(DEPTH)) && (count[DEPTH_BITS-1:0] == (wrPtr - rdPtr)))
        else $error("FIFO count above depth or out of step with pointers");

endmodule

`default_nettype wire

/* verilog/uartBusPkg.sv */
`default_nettype none

`include "uart_params.svh"

package busPkg;

    // Word addresses seen on the slave port
    typedef enum logic [`UART_ADDR_BITS-1:0] {
        REG_CTRL = 0,
        REG_DATA = 1
    } regAddr_t;

    // Control register read layout, divisor in 15..0
    localparam int DIV_MSB       = 15;
    localparam int STAT_TX_IDLE  = 16;
    localparam int STAT_RX_AVAIL = 17;
    localparam int STAT_TX_FULL  = 18;

endpackage

`default_nettype wire

/* verilog/uartLinePkg.sv */
`default_nettype none

package uartLinePkg;

    // Transmit frame phases
    typedef enum logic [1:0] {
        TX_IDLE_S,
        TX_START_S,
        TX_DATA_S,
        TX_STOP_S
    } txState_t;

    // Receive frame phases
    typedef enum logic [1:0] {
        RX_IDLE_S,
        RX_START_S,
        RX_DATA_S,
        RX_STOP_S
    } rxState_t;

endpackage

`default_nettype wire

/* verilog/uartPeriph.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module uartPeriph (
    input  wire logic                       i_Clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_SlaveSel,
    input  wire logic [`UART_ADDR_BITS-1:0] i_RegAddr,
    input  wire logic [3:0]                 i_ByteEn,
    input  wire logic                       i_Read,
    input  wire logic                       i_Write,
    input  wire logic [31:0]                i_WriteData,
    input  wire logic                       i_UartRx,
    output logic      [31:0]                o_ReadData,
    output logic                            o_UartTx
);

    logic [15:0] clksPerBit;
    logic        txPush;
    logic [7:0]  txPushData;
    logic        txLaunch;
    logic [7:0]  txHead;
    logic        txEmpty;
    logic        txFull;
    logic        txIdle;
    logic        rxPop;
    logic [7:0]  rxHead;
    logic        rxEmpty;
    logic        rxValid;
    logic [7:0]  rxByte;

    uartRegFile regFile0 (
        .i_Clk        (i_Clk),
        .i_rst        (i_rst),
        .i_SlaveSel   (i_SlaveSel),
        .i_RegAddr    (i_RegAddr),
        .i_ByteEn     (i_ByteEn),
        .i_Read       (i_Read),
        .i_Write      (i_Write),
        .i_WriteData  (i_WriteData),
        .i_TxEmpty    (txEmpty),
        .i_TxFull     (txFull),
        .i_TxIdle     (txIdle),
        .i_RxEmpty    (rxEmpty),
        .i_RxData     (rxHead),
        .o_ReadData   (o_ReadData),
        .o_ClksPerBit (clksPerBit),
        .o_TxPush     (txPush),
        .o_TxPushData (txPushData),
        .o_TxLaunch   (txLaunch),
        .o_RxPop      (rxPop)
    );

    byteFifo #(.DEPTH_BITS(`UART_FIFO_PTR_BITS)) txFifo (
        .i_Clk    (i_Clk),
        .i_rst    (i_rst),
        .i_WrEn   (txPush),
        .i_WrData (txPushData),
        .i_RdEn   (txLaunch),
        .o_RdData (txHead),
        .o_Full   (txFull),
        .o_Empty  (txEmpty)
    );

    byteFifo #(.DEPTH_BITS(`UART_FIFO_PTR_BITS)) rxFifo (
        .i_Clk    (i_Clk),
        .i_rst    (i_rst),
        .i_WrEn   (rxValid),
        .i_WrData (rxByte),
        .i_RdEn   (rxPop),
        .o_RdData (rxHead),
        .o_Full   (),
        .o_Empty  (rxEmpty)
    );

    uartTx tx0 (
        .i_Clk        (i_Clk),
        .i_rst        (i_rst),
        .i_ClksPerBit (clksPerBit),
        .i_Start      (txLaunch),
        .i_Data       (txHead),
        .o_Idle       (txIdle),
        .o_UartTx     (o_UartTx)
    );

    uartRx rx0 (
        .i_Clk        (i_Clk),
        .i_rst        (i_rst),
        .i_ClksPerBit (clksPerBit),
        .i_UartRx     (i_UartRx),
        .o_Valid      (rxValid),
        .o_Data       (rxByte)
    );

endmodule

`default_nettype wire

/* verilog/uartRegFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module uartRegFile (
    input  wire logic                       i_Clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_SlaveSel,
    input  wire logic [`UART_ADDR_BITS-1:0] i_RegAddr,
    input  wire logic [3:0]                 i_ByteEn,
    input  wire logic                       i_Read,
    input  wire logic                       i_Write,
    input  wire logic [31:0]                i_WriteData,
    input  wire logic                       i_TxEmpty,
    input  wire logic                       i_TxFull,
    input  wire logic                       i_TxIdle,
    input  wire logic                       i_RxEmpty,
    input  wire logic [7:0]                 i_RxData,
    output logic      [31:0]                o_ReadData,
    output logic      [15:0]                o_ClksPerBit,
    output logic                            o_TxPush,
    output logic      [7:0]                 o_TxPushData,
    output logic                            o_TxLaunch,
    output logic                            o_RxPop
);

    logic [15:0]      clksPerBit;
    logic [31:0]      statusWord;
    logic             selRead;
    logic             selWrite;
    logic             dataWrite;
    busPkg::regAddr_t regAddr;

    assign regAddr   = busPkg::regAddr_t'(i_RegAddr);
    assign selRead   = i_SlaveSel && i_Read;
    assign selWrite  = i_SlaveSel && i_Write;
    assign dataWrite = selWrite && (regAddr == busPkg::REG_DATA) && i_ByteEn[0];

    // Divisor sits in the low two bytes of the control register
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            clksPerBit <= 16'(`UART_RESET_CLKS_PER_BIT);
        end else if (selWrite && (regAddr == busPkg::REG_CTRL)) begin
            if (i_ByteEn[0]) begin
                clksPerBit[7:0] <= i_WriteData[7:0];
            end
            if (i_ByteEn[1]) begin
                clksPerBit[15:8] <= i_WriteData[15:8];
            end
        end
    end

    assign o_ClksPerBit = clksPerBit;

    // FIFO sees the registered push strobe one cycle after the write
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            o_TxPush <= 1'b0;
        end else begin
            o_TxPush <= dataWrite;
        end
    end

    always_ff @(posedge i_Clk) begin
        if (dataWrite) begin
            o_TxPushData <= i_WriteData[7:0];
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[busPkg::DIV_MSB:0]       = clksPerBit;
        statusWord[busPkg::STAT_TX_IDLE]  = i_TxEmpty && i_TxIdle;
        statusWord[busPkg::STAT_RX_AVAIL] = !i_RxEmpty;
        statusWord[busPkg::STAT_TX_FULL]  = i_TxFull;
    end

    // Pop happens on the same edge that captures the head byte
    assign o_RxPop = selRead && (regAddr == busPkg::REG_DATA) && !i_RxEmpty;

    // Read data is valid one cycle after the read and zero otherwise
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            o_ReadData <= '0;
        end else begin
            o_ReadData <= '0;
            if (selRead) begin
                case (regAddr)
                    busPkg::REG_CTRL: begin
                        o_ReadData <= statusWord;
                    end
                    busPkg::REG_DATA: begin
                        if (!i_RxEmpty) begin
                            o_ReadData <= {24'b0, i_RxData};
                        end
                    end
                endcase
            end
        end
    end

    // Launch pulse pops the FIFO and starts the transmitter
    // Idle still reads high in the cycle right after a launch
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            o_TxLaunch <= 1'b0;
        end else begin
            o_TxLaunch <= !i_TxEmpty && i_TxIdle && !o_TxLaunch;
        end
    end

    assert property (@(posedge i_Clk) disable iff (i_rst)
        o_TxLaunch |=> (!o_TxLaunch && !i_TxIdle))
        else $error("txLaunch repeated or transmitter still idle after launch");

endmodule

`default_nettype wire

/* verilog/uartRx.sv */
`timescale 1ns/10ps
`default_nettype none

module uartRx (
    input  wire logic        i_Clk,
    input  wire logic        i_rst,
    input  wire logic [15:0] i_ClksPerBit,
    input  wire logic        i_UartRx,
    output logic             o_Valid,
    output logic      [7:0]  o_Data
);

    uartLinePkg::rxState_t state;
    logic                  rxMeta;
    logic                  rxSync;
    logic                  rxPrev;
    logic [15:0]           bitCnt;
    logic [7:0]            shiftReg;
    logic [2:0]            bitIdx;
    logic                  halfDone;
    logic                  bitDone;

    // Two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= i_UartRx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    assign halfDone = (bitCnt == (i_ClksPerBit >> 1) - 16'd1);
    assign bitDone  = (bitCnt == i_ClksPerBit - 16'd1);

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state   <= uartLinePkg::RX_IDLE_S;
            bitCnt  <= '0;
            bitIdx  <= '0;
            o_Valid <= 1'b0;
        end else begin
            o_Valid <= 1'b0;
            case (state)
                uartLinePkg::RX_IDLE_S: begin
                    bitCnt <= '0;
                    if (rxPrev && !rxSync) begin
                        state <= uartLinePkg::RX_START_S;
                    end
                end
                uartLinePkg::RX_START_S: begin
                    bitCnt <= bitCnt + 16'd1;
                    if (halfDone) begin
                        bitCnt <= '0;
                        bitIdx <= '0;
                        // Glitch, not a start bit
                        if (rxSync) begin
                            state <= uartLinePkg::RX_IDLE_S;
                        end else begin
                            state <= uartLinePkg::RX_DATA_S;
                        end
                    end
                end
                uartLinePkg::RX_DATA_S: begin
                    bitCnt <= bitCnt + 16'd1;
                    if (bitDone) begin
                        bitCnt <= '0;
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) begin
                            state <= uartLinePkg::RX_STOP_S;
                        end
                    end
                end
                uartLinePkg::RX_STOP_S: begin
                    bitCnt <= bitCnt + 16'd1;
                    if (bitDone) begin
                        bitCnt  <= '0;
                        o_Valid <= rxSync;
                        state   <= uartLinePkg::RX_IDLE_S;
                    end
                end
                default: state <= uartLinePkg::RX_IDLE_S;
            endcase
        end
    end

    // Mid-bit samples shift in from the top, LSB first on the line
    always_ff @(posedge i_Clk) begin
        if ((state == uartLinePkg::RX_DATA_S) && bitDone) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
        if ((state == uartLinePkg::RX_STOP_S) && bitDone) begin
            o_Data <= shiftReg;
        end
    end

endmodule

`default_nettype wire

/* verilog/uartTx.sv */
`timescale 1ns/10ps
`default_nettype none

module uartTx (
    input  wire logic        i_Clk,
    input  wire logic        i_rst,
    input  wire logic [15:0] i_ClksPerBit,
    input  wire logic        i_Start,
    input  wire logic [7:0]  i_Data,
    output logic             o_Idle,
    output logic             o_UartTx
);

    uartLinePkg::txState_t state;
    logic [15:0]           bitCnt;
    logic [7:0]            shiftReg;
    logic [2:0]            bitIdx;
    logic                  bitDone;

    assign bitDone = (bitCnt == i_ClksPerBit - 16'd1);
    assign o_Idle  = (state == uartLinePkg::TX_IDLE_S);

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state    <= uartLinePkg::TX_IDLE_S;
            bitCnt   <= '0;
            bitIdx   <= '0;
            o_UartTx <= 1'b1;
        end else begin
            case (state)
                uartLinePkg::TX_IDLE_S: begin
                    o_UartTx <= 1'b1;
                    bitCnt   <= '0;
                    if (i_Start) begin
                        o_UartTx <= 1'b0;
                        state    <= uartLinePkg::TX_START_S;
                    end
                end
                uartLinePkg::TX_START_S: begin
                    bitCnt <= bitCnt + 16'd1;
                    if (bitDone) begin
                        bitCnt   <= '0;
                        bitIdx   <= '0;
                        o_UartTx <= shiftReg[0];
                        state    <= uartLinePkg::TX_DATA_S;
                    end
                end
                uartLinePkg::TX_DATA_S: begin
                    bitCnt <= bitCnt + 16'd1;
                    if (bitDone) begin
                        bitCnt <= '0;
                        bitIdx <= bitIdx + 3'd1;
                        if (bitIdx == 3'd7) begin
                            o_UartTx <= 1'b1;
                            state    <= uartLinePkg::TX_STOP_S;
                        end else begin
                            o_UartTx <= shiftReg[1];
                        end
                    end
                end
                uartLinePkg::TX_STOP_S: begin
                    bitCnt <= bitCnt + 16'd1;
                    if (bitDone) begin
                        bitCnt <= '0;
                        state  <= uartLinePkg::TX_IDLE_S;
                    end
                end
                default: state <= uartLinePkg::TX_IDLE_S;
            endcase
        end
    end

    // Shift register, LSB goes out first
    always_ff @(posedge i_Clk) begin
        if (o_Idle && i_Start) begin
            shiftReg <= i_Data;
        end else if ((state == uartLinePkg::TX_DATA_S) && bitDone) begin
            shiftReg <= {1'b0, shiftReg[7:1]};
        end
    end

    assert property (@(posedge i_Clk) disable iff (i_rst) i_Start |-> o_Idle)
        else $error("Transmit start while busy");

endmodule

`default_nettype wire

/* verilog/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Word address width inside the peripheral, two registers
`define UART_ADDR_BITS 1

// Entries per byte FIFO and the matching pointer width
`define UART_FIFO_DEPTH 16
`define UART_FIFO_PTR_BITS 4

// Divisor loaded at reset
`define UART_RESET_CLKS_PER_BIT 16

`endif
